// File: bench/led_matrix_tests.txt
# W adr data sel = write | R adr expected = read | F row = check next scan of row
# all values hex, adr is half, row, column
W 000 00A1B2C3 F
R 000 00A1B2C3
W 000 FF112233 1
R 000 00A1B233
W 000 00445566 6
R 000 00445533
W 000 00998877 0
R 000 00445533
W 000 DE0000FF 8
R 000 00445533
W 11F 00FF00FF 7
R 11F 00FF00FF
W 0A3 00123456 7
R 0A3 00123456
W 1A3 0080C001 7
R 1A3 0080C001
F 0
F 5
W 01E 00FFFFFF 7
F 0
R 01E 00FFFFFF
W 17F 00010203 7
F 3
R 17F 00010203

// File: filelist.f
hw/led_matrix_pkg.sv
hw/matrix_fb.sv
hw/hub75_scanner.sv
hw/led_matrix_top.sv
bench/led_matrix_assertions.sv
bench/tb_led_matrix.sv

// File: Makefile
SRCS := $(shell cat filelist.f)

.PHONY: all run clean

all: obj_dir/Vtb_led_matrix

obj_dir/Vtb_led_matrix: $(SRCS) filelist.f
	verilator --binary --timing --assert -j 0 --top-module tb_led_matrix -f filelist.f

run: obj_dir/Vtb_led_matrix
	@out=$$(./obj_dir/Vtb_led_matrix); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

// File: bench/tb_led_matrix.sv
`default_nettype none
`timescale 1ns/1ns

module tb_led_matrix;

  localparam int COL_BITS   = 5;
  localparam int ROW_BITS   = 3;
  localparam int NPIX       = 2 ** (1 + ROW_BITS + COL_BITS);
  localparam int ROW_PERIOD = 8 * 129 + 509 + 8;  // weights sum to 509

  logic                    clk;
  logic                    rst;
  led_matrix_pkg::wb_req_t req;
  led_matrix_pkg::wb_rsp_t rsp;
  led_matrix_pkg::hub75_t  hub;
  logic [ROW_BITS-1:0]     row;

  led_matrix_pkg::pixel_t shadow [NPIX];
  byte                    cmd_q [$];
  logic [31:0]            a0_q [$];
  logic [31:0]            a1_q [$];
  logic [31:0]            a2_q [$];
  int                     errors = 0;
  int                     checks = 0;
  logic [31:0]            sr0 [3];  // panel shift registers, r g b
  logic [31:0]            sr1 [3];
  logic [2:0]             tb_plane = 3'd7;
  logic [ROW_BITS-1:0]    exp_row = '0;
  int                     oe_len = 0;
  logic                   armed = 1'b0;
  int                     latches = 0;

  led_matrix_top #(
    .COL_BITS (COL_BITS),
    .ROW_BITS (ROW_BITS)
  ) i_dut (
    .clk_i    (clk),
    .rst_i    (rst),
    .wb_req_i (req),
    .wb_rsp_o (rsp),
    .hub75_o  (hub),
    .row_o    (row)
  );

  always #4 clk = ~clk;

  // top plane runs 255, the rest double per plane from 2
  function automatic int plane_weight(input logic [2:0] p);
    case (p)
      3'd7:    return 255;
      3'd6:    return 128;
      3'd5:    return 64;
      3'd4:    return 32;
      3'd3:    return 16;
      3'd2:    return 8;
      3'd1:    return 4;
      default: return 2;
    endcase
  endfunction

  function automatic logic chan_bit(input led_matrix_pkg::pixel_t p, input int ch,
                                    input logic [2:0] pl);
    if (ch == 2) begin
      return p.r[pl];
    end else if (ch == 1) begin
      return p.g[pl];
    end
    return p.b[pl];
  endfunction

  function automatic led_matrix_pkg::pixel_t fill_pixel(input logic [8:0] adr);
    logic [23:0] v;
    v = {15'd0, adr} * 24'h01F3A7;
    return v ^ 24'hC35A96;
  endfunction

  task automatic masked_update(input logic [8:0] adr, input logic [31:0] dat,
                               input logic [3:0] sel);
    if (sel[0]) shadow[adr].b = dat[7:0];
    if (sel[1]) shadow[adr].g = dat[15:8];
    if (sel[2]) shadow[adr].r = dat[23:16];
  endtask

  task automatic wb_access(input logic we, input logic [8:0] adr, input logic [31:0] dat,
                           input logic [3:0] sel, output logic [31:0] rdat);
    led_matrix_pkg::wb_req_t r;
    int n;
    r = '0;
    r.cyc = 1'b1;
    r.stb = 1'b1;
    r.we  = we;
    r.sel = sel;
    r.adr = adr;
    r.dat = dat;
    n = 0;
    @(posedge clk);
    req <= r;
    do begin
      @(negedge clk);
      n++;
    end while (!rsp.ack);
    rdat = rsp.dat;
    checks++;
    assert (n == 3) else begin
      errors++;
      $display("[FAIL] %0t ack latency at adr %h was %0d cycles", $time, adr, n - 1);
    end
    @(posedge clk);
    req <= '0;
    if (we) masked_update(adr, dat, sel);
    repeat ($urandom_range(0, 3)) @(posedge clk);  // idle gap
  endtask

  task automatic fill_memory();
    logic [31:0] rd;
    for (int a = 0; a < NPIX; a++) begin
      wb_access(1'b1, 9'(a), {8'h00, fill_pixel(9'(a))}, 4'hF, rd);
    end
  endtask

  // wait for a fresh pass over the row, then check all its planes
  task automatic check_row_frame(input logic [ROW_BITS-1:0] r);
    do @(negedge clk); while (row == r);
    do @(negedge clk); while (row != r);
    latches = 0;
    armed = 1'b1;
    wait (!armed);
  endtask

  // panel capture model
  always @(negedge clk) begin
    logic [31:0] expv;
    if (!rst) begin
      if (hub.sclk) begin
        for (int ch = 0; ch < 3; ch++) begin
          sr0[ch] = {sr0[ch][30:0], hub.rgb0[ch]};
          sr1[ch] = {sr1[ch][30:0], hub.rgb1[ch]};
        end
      end
      if (hub.lat && armed) begin
        for (int ch = 0; ch < 3; ch++) begin
          for (int h = 0; h < 2; h++) begin
            for (int c = 0; c < 32; c++) begin
              expv[31-c] = chan_bit(shadow[{h[0], exp_row, c[4:0]}], ch, tb_plane);
            end
            checks++;
            assert ((h == 0 ? sr0[ch] : sr1[ch]) === expv) else begin
              errors++;
              $display("[FAIL] %0t row %0d plane %0d half %0d ch %0d latched %h expected %h",
                       $time, exp_row, tb_plane, h, ch, (h == 0 ? sr0[ch] : sr1[ch]), expv);
            end
          end
        end
        latches++;
        if (latches == 8) armed = 1'b0;
      end
      if (!hub.oe_n) begin
        oe_len++;
      end else if (oe_len != 0) begin
        checks++;
        assert (oe_len == plane_weight(tb_plane) + 1) else begin
          errors++;
          $display("[FAIL] %0t plane %0d enable lasted %0d cycles", $time, tb_plane, oe_len);
        end
        oe_len = 0;
        if (tb_plane == 3'd0) begin
          exp_row = exp_row + 1'b1;
        end
        tb_plane = tb_plane - 3'd1;  // wraps 0 to 7
      end
      assert (row == exp_row) else begin
        errors++;
        $display("[FAIL] %0t row_o is %0d, expected %0d", $time, row, exp_row);
      end
    end
  end

  initial begin
    int fd;
    string line;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] s;
    logic [31:0] rd;
    longint limit;
    int frames;
    clk = 1'b0;
    rst = 1'b1;
    req = '0;
    void'($urandom(32'h4770));
    fd = $fopen("bench/led_matrix_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open the test data file bench/led_matrix_tests.txt");
      $display("Simulation failed");
      $finish;
    end else begin
      frames = 0;
      while ($fgets(line, fd) != 0) begin
        if (line.len() < 2 || line.getc(0) == "#") continue;
        a = '0;
        d = '0;
        s = '0;
        void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, d, s));
        cmd_q.push_back(line.getc(0));
        a0_q.push_back(a);
        a1_q.push_back(d);
        a2_q.push_back(s);
        if (line.getc(0) == "F") frames++;
      end
      $fclose(fd);
      limit = longint'(cmd_q.size() + NPIX) * 20 + longint'(frames + 2) * 8 * ROW_PERIOD;
      fork
        begin
          repeat (limit) @(posedge clk);
          $display("watchdog expired, the DUT stopped responding");
          $display("Simulation failed");
          $finish;
        end
      join_none
      for (int i = 0; i < 3; i++) begin
        @(negedge clk);
        checks++;
        assert (hub.oe_n && !hub.sclk && !hub.lat && row == '0) else begin
          errors++;
          $display("[FAIL] %0t panel outputs not idle during reset", $time);
        end
      end
      @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      checks++;
      assert (hub.oe_n && !hub.sclk && !hub.lat && row == '0 && !rsp.ack) else begin
        errors++;
        $display("[FAIL] %0t outputs wrong just after reset", $time);
      end
      fill_memory();
      foreach (cmd_q[i]) begin
        if (cmd_q[i] == "W") begin
          wb_access(1'b1, a0_q[i][8:0], a1_q[i], a2_q[i][3:0], rd);
        end else if (cmd_q[i] == "R") begin
          wb_access(1'b0, a0_q[i][8:0], '0, 4'hF, rd);
          checks++;
          assert (rd == a1_q[i] && rd == {8'h00, shadow[a0_q[i][8:0]]}) else begin
            errors++;
            $display("[FAIL] %0t read %h returned %h, expected %h", $time, a0_q[i][8:0],
                     rd, a1_q[i]);
          end
        end else begin
          check_row_frame(a0_q[i][ROW_BITS-1:0]);
        end
      end
      $display("checks: %0d  errors: %0d", checks, errors);
      if (errors == 0) begin
        $display("Simulation completed successfully");
      end else begin
        $display("Simulation failed");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: bench/led_matrix_assertions.sv
`default_nettype none
`timescale 1ns/1ns

module led_matrix_assertions #(
  parameter int ROW_BITS = 3
) (
  input wire                         clk_i,
  input wire                         rst_i,
  input led_matrix_pkg::hub75_t      hub75_i,
  input wire [ROW_BITS-1:0]          row_i
);

  sclk_lat_apart: assert property (@(posedge clk_i) disable iff (rst_i)
    !(hub75_i.sclk && hub75_i.lat))
    else $error("sclk and lat high in the same cycle");

  dark_while_shifting: assert property (@(posedge clk_i) disable iff (rst_i)
    (hub75_i.sclk || hub75_i.lat) |-> hub75_i.oe_n)
    else $error("outputs enabled during shift or latch");

  // row address only moves with the panel dark
  row_change_dark: assert property (@(posedge clk_i) disable iff (rst_i)
    (row_i != $past(row_i)) |-> hub75_i.oe_n)
    else $error("row address changed with outputs enabled");

endmodule

bind hub75_scanner led_matrix_assertions #(.ROW_BITS(ROW_BITS)) i_assertions (
  .clk_i   (clk_i),
  .rst_i   (rst_i),
  .hub75_i (hub75_o),
  .row_i   (row_o)
);

`default_nettype wire

// File: hw/led_matrix_top.sv
`default_nettype none
`timescale 1ns/1ns

module led_matrix_top #(
  parameter int COL_BITS = 5,
  parameter int ROW_BITS = 3
) (
  input  wire                        clk_i,
  input  wire                        rst_i,
  input  led_matrix_pkg::wb_req_t    wb_req_i,
  output led_matrix_pkg::wb_rsp_t    wb_rsp_o,
  output led_matrix_pkg::hub75_t     hub75_o,
  output logic [ROW_BITS-1:0]        row_o
);

  localparam int AW = 1 + ROW_BITS + COL_BITS;

  // scanner to framebuffer read port
  logic [AW-1:0]          scan_adr;
  led_matrix_pkg::pixel_t scan_pix;

  matrix_fb #(
    .COL_BITS (COL_BITS),
    .ROW_BITS (ROW_BITS)
  ) i_fb (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .wb_req_i   (wb_req_i),
    .wb_rsp_o   (wb_rsp_o),
    .scan_adr_i (scan_adr),
    .scan_pix_o (scan_pix)
  );

  hub75_scanner #(
    .COL_BITS (COL_BITS),
    .ROW_BITS (ROW_BITS)
  ) i_scanner (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .scan_adr_o (scan_adr),
    .scan_pix_i (scan_pix),
    .hub75_o    (hub75_o),
    .row_o      (row_o)
  );

endmodule

`default_nettype wire

// File: hw/hub75_scanner.sv
`default_nettype none
`timescale 1ns/1ns

module hub75_scanner #(
  parameter int COL_BITS = 5,
  parameter int ROW_BITS = 3
) (
  input  wire                            clk_i,
  input  wire                            rst_i,
  output logic [ROW_BITS+COL_BITS:0]     scan_adr_o,
  input  led_matrix_pkg::pixel_t         scan_pix_i,
  output led_matrix_pkg::hub75_t         hub75_o,
  output logic [ROW_BITS-1:0]            row_o
);

  localparam int PLANE_W  = led_matrix_pkg::PLANE_W;
  localparam int WEIGHT_W = led_matrix_pkg::WEIGHT_W;
  localparam logic [COL_BITS-1:0] LAST_COL = '1;
  localparam logic [PLANE_W-1:0]  TOP_PLANE = PLANE_W'(led_matrix_pkg::PWM_BITS - 1);

  typedef enum logic [2:0] {
    S_FETCH_HI,  // upper address out
    S_FETCH_LO,  // lower address out, upper pixel back
    S_CAPTURE,   // lower pixel back
    S_SHIFT,     // sclk high
    S_LATCH,
    S_ENABLE
  } state_t;

  state_t                state_q;
  state_t                state_d;
  logic [COL_BITS-1:0]   col_q;
  logic [COL_BITS-1:0]   col_d;
  logic [ROW_BITS-1:0]   row_q;
  logic [ROW_BITS-1:0]   row_d;
  logic [PLANE_W-1:0]    plane_q;
  logic [PLANE_W-1:0]    plane_d;
  logic [WEIGHT_W-1:0]   delay_q;
  logic [WEIGHT_W-1:0]   delay_d;
  logic [2:0]            plane_bits;
  logic [2:0]            rgb0_q;
  logic [2:0]            rgb1_q;
  logic                  half_sel;

  // current plane bit of each channel, in r g b order
  function automatic logic [2:0] pick_bits(input led_matrix_pkg::pixel_t pix,
                                           input logic [PLANE_W-1:0] plane);
    logic [2:0] bits;
    bits[2] = pix.r[plane];
    bits[1] = pix.g[plane];
    bits[0] = pix.b[plane];
    return bits;
  endfunction

  assign plane_bits = pick_bits(scan_pix_i, plane_q);

  assign half_sel   = (state_q != S_FETCH_HI);
  assign scan_adr_o = {half_sel, row_q, col_q};

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= S_FETCH_HI;
      col_q   <= '0;
      row_q   <= '0;
      plane_q <= TOP_PLANE;
      delay_q <= '0;
    end else begin
      state_q <= state_d;
      col_q   <= col_d;
      row_q   <= row_d;
      plane_q <= plane_d;
      delay_q <= delay_d;
    end
  end

  always_comb begin
    state_d = state_q;
    col_d   = col_q;
    row_d   = row_q;
    plane_d = plane_q;
    delay_d = delay_q;
    case (state_q)
      S_FETCH_HI: begin
        state_d = S_FETCH_LO;
      end
      S_FETCH_LO: begin
        state_d = S_CAPTURE;
      end
      S_CAPTURE: begin
        state_d = S_SHIFT;
      end
      S_SHIFT: begin
        col_d = col_q + 1'b1;  // wraps back to 0 after the last column
        if (col_q == LAST_COL) begin
          state_d = S_LATCH;
        end else begin
          state_d = S_FETCH_HI;
        end
      end
      S_LATCH: begin
        state_d = S_ENABLE;
        delay_d = led_matrix_pkg::bcm_weight(plane_q);
      end
      S_ENABLE: begin
        if (delay_q == '0) begin
          state_d = S_FETCH_HI;
          plane_d = plane_q - 1'b1;
          if (plane_q == '0) begin
            row_d = row_q + 1'b1;  // all planes done for this row
          end
        end else begin
          delay_d = delay_q - 1'b1;
        end
      end
      default: begin
        state_d = S_FETCH_HI;
      end
    endcase
  end

  // colour bits stay put through the sclk cycle
  always_ff @(posedge clk_i) begin
    if (state_q == S_FETCH_LO) begin
      rgb0_q <= plane_bits;
    end
    if (state_q == S_CAPTURE) begin
      rgb1_q <= plane_bits;
    end
  end

  assign hub75_o.rgb0 = rgb0_q;
  assign hub75_o.rgb1 = rgb1_q;
  assign hub75_o.sclk = (state_q == S_SHIFT);
  assign hub75_o.lat  = (state_q == S_LATCH);
  assign hub75_o.oe_n = (state_q != S_ENABLE);

  assign row_o = row_q;

endmodule

`default_nettype wire

// File: hw/matrix_fb.sv
`default_nettype none
`timescale 1ns/1ns

module matrix_fb #(
  parameter int COL_BITS = 5,
  parameter int ROW_BITS = 3
) (
  input  wire                            clk_i,
  input  wire                            rst_i,
  input  led_matrix_pkg::wb_req_t        wb_req_i,
  output led_matrix_pkg::wb_rsp_t        wb_rsp_o,
  input  wire [ROW_BITS+COL_BITS:0]      scan_adr_i,
  output led_matrix_pkg::pixel_t         scan_pix_o
);

  localparam int AW    = 1 + ROW_BITS + COL_BITS;
  localparam int DEPTH = 2 ** AW;
  localparam int CW    = led_matrix_pkg::COLOR_W;

  led_matrix_pkg::pixel_t mem [DEPTH];

  logic [AW-1:0]          wb_adr;
  logic                   wb_sel;
  logic                   wr_en;
  logic [1:0]             ack_q;
  led_matrix_pkg::pixel_t wb_rd_q;

  assign wb_adr = wb_req_i.adr[AW-1:0];
  assign wb_sel = wb_req_i.cyc & wb_req_i.stb;

  // write lands in the ack cycle
  assign wr_en = wb_sel & wb_req_i.we & ack_q[1];

  // two stage ack, no restart until the ack has gone out
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      ack_q <= '0;
    end else begin
      ack_q[0] <= wb_sel & ~(|ack_q);
      ack_q[1] <= ack_q[0];
    end
  end

  // host port
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      if (wb_req_i.sel[0]) begin
        mem[wb_adr].b <= wb_req_i.dat[CW-1:0];
      end
      if (wb_req_i.sel[1]) begin
        mem[wb_adr].g <= wb_req_i.dat[2*CW-1:CW];
      end
      if (wb_req_i.sel[2]) begin
        mem[wb_adr].r <= wb_req_i.dat[3*CW-1:2*CW];
      end
      // sel[3] has no storage behind it
    end
    wb_rd_q <= mem[wb_adr];  // valid by the ack cycle
  end

  // scan port, read only
  always_ff @(posedge clk_i) begin
    scan_pix_o <= mem[scan_adr_i];
  end

  assign wb_rsp_o.ack = ack_q[1];
  assign wb_rsp_o.dat = {8'h00, wb_rd_q};  // top byte reads as zero

endmodule

`default_nettype wire

// File: hw/led_matrix_pkg.sv
`default_nettype none

package led_matrix_pkg;

  localparam int COLOR_W  = 8;
  localparam int ADR_W    = 9;   // wishbone word address, half + row + column
  localparam int PWM_BITS = 8;   // bit planes per row
  localparam int PLANE_W  = $clog2(PWM_BITS);
  localparam int WEIGHT_W = 8;

  // one framebuffer word, blue in the low byte
  typedef struct packed {
    logic [COLOR_W-1:0] r;
    logic [COLOR_W-1:0] g;
    logic [COLOR_W-1:0] b;
  } pixel_t;

  // panel connector signals
  typedef struct packed {
    logic [2:0] rgb0;  // upper half
    logic [2:0] rgb1;  // lower half
    logic       sclk;
    logic       lat;
    logic       oe_n;
  } hub75_t;

  typedef struct packed {
    logic             cyc;
    logic             stb;
    logic             we;
    logic [3:0]       sel;
    logic [ADR_W-1:0] adr;
    logic [31:0]      dat;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

  // enable time of a plane, top plane gets the full 255
  function automatic logic [WEIGHT_W-1:0] bcm_weight(input logic [PLANE_W-1:0] plane);
    logic [WEIGHT_W-1:0] w;
    if (plane == PLANE_W'(PWM_BITS - 1))
      w = '1;
    else
      w = WEIGHT_W'(2 << plane);
    return w;
  endfunction

endpackage

`default_nettype wire
